/* src/wino_settings.svh */
`ifndef WINO_SETTINGS_SVH
`define WINO_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Inverse transform datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define WINO_ACC_W    30 // Accumulator word.
`define WINO_PIX_W    16 // Output pixel.
`define WINO_FRAC_LSB 8  // Lowest accumulator bit kept in a pixel.

// F(4,3) tile sides.
`define WINO_TILE_IN  6
`define WINO_TILE_OUT 4

`endif

/* src/wino_num_pkg.sv */
`default_nettype none

`include "wino_settings.svh"

package wino_num_pkg;

	// Signed word coming out of the element-wise product stage.
	typedef logic signed [`WINO_ACC_W-1:0] acc_t;

	typedef logic [`WINO_PIX_W-1:0] pix_t; // Rectified output pixel.

endpackage

`default_nettype wire

/* src/wino_tile_pkg.sv */
`default_nettype none

package wino_tile_pkg;

	import wino_num_pkg::*;

	// Input column, or a transposed row of stage-1 results.
	typedef struct packed {
		acc_t e0;
		acc_t e1;
		acc_t e2;
		acc_t e3;
		acc_t e4;
		acc_t e5;
	} acc_vec6_t;

	typedef struct packed {
		acc_t e0;
		acc_t e1;
		acc_t e2;
		acc_t e3;
	} acc_vec4_t; // One A^T product.

	typedef struct packed {
		pix_t p0;
		pix_t p1;
		pix_t p2;
		pix_t p3;
	} pix_row_t; // Output row with p0 as column 0.

endpackage

`default_nettype wire

/* src/wino_adder6.sv */
`timescale 1ns/10ps
`default_nettype none

module wino_adder6
	import wino_num_pkg::*, wino_tile_pkg::*;
(
	input  wire            clk,
	input  wire            i_arst_n,
	input  wire acc_vec6_t i_terms,
	output acc_t           o_sum
);

	acc_t s1_a;
	acc_t s1_b;
	acc_t s1_c;
	acc_t s2_ab;
	acc_t s2_c;
	acc_t s3_sum;

	// Three-level tree whose sums wrap at the accumulator width.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			s1_a   <= '0;
			s1_b   <= '0;
			s1_c   <= '0;
			s2_ab  <= '0;
			s2_c   <= '0;
			s3_sum <= '0;
		end else begin
			s1_a   <= i_terms.e0 + i_terms.e1;
			s1_b   <= i_terms.e2 + i_terms.e3;
			s1_c   <= i_terms.e4 + i_terms.e5;
			s2_ab  <= s1_a + s1_b;
			s2_c   <= s1_c; // Odd pair rides along.
			s3_sum <= s2_ab + s2_c;
		end
	end

	assign o_sum = s3_sum;

endmodule

`default_nettype wire

/* src/wino_at_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module wino_at_stage
	import wino_num_pkg::*, wino_tile_pkg::*;
(
	input  wire            clk,
	input  wire            i_arst_n,
	input  wire acc_vec6_t i_vec,
	output acc_vec4_t      o_vec
);

	acc_t      v2_n;
	acc_t      v3_x2;
	acc_t      v4_x2_n;
	acc_t      v3_x4;
	acc_t      v4_x4;
	acc_t      v3_x8;
	acc_t      v4_x8_n;
	acc_vec6_t terms [4];
	acc_t      sums  [4];

	// Scaled and negated operands of the A^T rows.
	assign v2_n    = -i_vec.e2;
	assign v3_x2   = i_vec.e3 <<< 1;
	assign v4_x2_n = -(i_vec.e4 <<< 1);
	assign v3_x4   = i_vec.e3 <<< 2;
	assign v4_x4   = i_vec.e4 <<< 2;
	assign v3_x8   = i_vec.e3 <<< 3;
	assign v4_x8_n = -(i_vec.e4 <<< 3);

	assign terms[0] = '{i_vec.e0, i_vec.e1, i_vec.e2, i_vec.e3, i_vec.e4, acc_t'(0)};
	assign terms[1] = '{acc_t'(0), i_vec.e1, v2_n, v3_x2, v4_x2_n, acc_t'(0)};
	assign terms[2] = '{acc_t'(0), i_vec.e1, i_vec.e2, v3_x4, v4_x4, acc_t'(0)};
	assign terms[3] = '{acc_t'(0), i_vec.e1, v2_n, v3_x8, v4_x8_n, i_vec.e5};

	for (genvar r = 0; r < 4; r++) begin : g_row
		wino_adder6 add0 (
			.clk      (clk),
			.i_arst_n (i_arst_n),
			.i_terms  (terms[r]),
			.o_sum    (sums[r])
		);
	end

	assign o_vec = '{sums[0], sums[1], sums[2], sums[3]};

endmodule

`default_nettype wire

/* src/wino_transpose_buf.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wino_settings.svh"

module wino_transpose_buf
	import wino_tile_pkg::*;
(
	input  wire            clk,
	input  wire            i_arst_n,
	input  wire acc_vec4_t i_col,
	input  wire            i_col_we,
	input  wire            i_drain_load,
	input  wire            i_row_shift,
	output acc_vec6_t      o_row
);

	acc_vec4_t cap       [`WINO_TILE_IN];  // Oldest column at index 0.
	acc_vec6_t drain     [`WINO_TILE_OUT]; // Row 0 at index 0.
	acc_vec6_t load_rows [`WINO_TILE_OUT];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Element r of each column becomes row r
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		load_rows[0] = '{cap[0].e0, cap[1].e0, cap[2].e0, cap[3].e0, cap[4].e0, cap[5].e0};
		load_rows[1] = '{cap[0].e1, cap[1].e1, cap[2].e1, cap[3].e1, cap[4].e1, cap[5].e1};
		load_rows[2] = '{cap[0].e2, cap[1].e2, cap[2].e2, cap[3].e2, cap[4].e2, cap[5].e2};
		load_rows[3] = '{cap[0].e3, cap[1].e3, cap[2].e3, cap[3].e3, cap[4].e3, cap[5].e3};
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int k = 0; k < `WINO_TILE_IN; k++) begin
				cap[k] <= '0;
			end
		end else if (i_col_we) begin
			for (int k = 0; k < `WINO_TILE_IN - 1; k++) begin
				cap[k] <= cap[k+1];
			end
			cap[`WINO_TILE_IN-1] <= i_col;
		end
	end

	// A load may share a cycle with the next block's first write.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int r = 0; r < `WINO_TILE_OUT; r++) begin
				drain[r] <= '0;
			end
		end else if (i_drain_load) begin
			drain <= load_rows;
		end else if (i_row_shift) begin
			for (int r = 0; r < `WINO_TILE_OUT - 1; r++) begin
				drain[r] <= drain[r+1];
			end
		end
	end

	assign o_row = drain[0];

endmodule

`default_nettype wire

/* src/wino_out_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wino_settings.svh"

module wino_out_ctrl (
	input  wire  clk,
	input  wire  i_arst_n,
	input  wire  i_valid,
	output logic o_col_we,
	output logic o_drain_load,
	output logic o_row_shift,
	output logic o_row_valid
);

	logic [2:0] we_dly;     // Matches stage-1 latency.
	logic [2:0] wr_cnt;
	logic       last_write;
	logic       drain_load;
	logic [2:0] rows_left;
	logic       drain_active;
	logic [2:0] act_dly;    // Matches stage-2 latency.

	assign o_col_we     = we_dly[2];
	assign last_write   = o_col_we && (wr_cnt == 3'(`WINO_TILE_IN - 1));
	assign drain_active = (rows_left != '0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Capture side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			we_dly     <= '0;
			wr_cnt     <= '0;
			drain_load <= 1'b0;
		end else begin
			we_dly     <= {we_dly[1:0], i_valid};
			drain_load <= last_write; // Capture is complete one cycle later.
			if (last_write) begin
				wr_cnt <= '0;
			end else if (o_col_we) begin
				wr_cnt <= wr_cnt + 3'd1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Drain side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rows_left <= '0;
			act_dly   <= '0;
		end else begin
			act_dly <= {act_dly[1:0], drain_active};
			if (drain_load) begin
				rows_left <= 3'(`WINO_TILE_OUT);
			end else if (drain_active) begin
				rows_left <= rows_left - 3'd1;
			end
		end
	end

	// Every row but the last is followed by a shift.
	assign o_row_shift  = (rows_left > 3'd1);
	assign o_drain_load = drain_load;
	assign o_row_valid  = act_dly[2];

endmodule

`default_nettype wire

/* src/wino_out_quant.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wino_settings.svh"

module wino_out_quant
	import wino_num_pkg::*, wino_tile_pkg::*;
(
	input  wire            clk,
	input  wire            i_arst_n,
	input  wire acc_vec4_t i_row,
	input  wire            i_row_valid,
	output pix_row_t       o_row,
	output logic           o_valid
);

	// Negative values clamp to zero and the high side does not saturate.
	function automatic pix_t rectify(input acc_t v);
		if (v[`WINO_ACC_W-1]) begin
			return '0;
		end
		return v[`WINO_FRAC_LSB +: `WINO_PIX_W];
	endfunction

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_row_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_row_valid) begin
			o_row <= '{rectify(i_row.e0), rectify(i_row.e1), rectify(i_row.e2),
				rectify(i_row.e3)};
		end
	end

endmodule

`default_nettype wire

/* src/wino_inverse_xform.sv */
`timescale 1ns/10ps
`default_nettype none

module wino_inverse_xform
	import wino_tile_pkg::*;
(
	input  wire            clk,
	input  wire            i_arst_n,
	input  wire            i_valid,
	input  wire acc_vec6_t i_col,
	output logic           o_valid,
	output pix_row_t       o_row
);

	logic      col_we;
	logic      drain_load;
	logic      row_shift;
	logic      row_valid;
	acc_vec4_t col_xf;  // A^T times one input column.
	acc_vec6_t buf_row; // Transposed row of stage-1 results.
	acc_vec4_t row_xf;

	wino_out_ctrl ctrl0 (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_valid      (i_valid),
		.o_col_we     (col_we),
		.o_drain_load (drain_load),
		.o_row_shift  (row_shift),
		.o_row_valid  (row_valid)
	);

	wino_at_stage col_stage0 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_vec    (i_col),
		.o_vec    (col_xf)
	);

	wino_transpose_buf buf0 (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_col        (col_xf),
		.i_col_we     (col_we),
		.i_drain_load (drain_load),
		.i_row_shift  (row_shift),
		.o_row        (buf_row)
	);

	wino_at_stage row_stage0 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_vec    (buf_row),
		.o_vec    (row_xf)
	);

	wino_out_quant quant0 (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_row       (row_xf),
		.i_row_valid (row_valid),
		.o_row       (o_row),
		.o_valid     (o_valid)
	);

endmodule

`default_nettype wire

/* dv/wino_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module wino_assert (
	input wire clk,
	input wire i_arst_n,
	input wire i_col_we,
	input wire i_drain_load,
	input wire i_row_shift,
	input wire i_row_valid
);

	logic [2:0] n_we;     // Column writes seen in the current block.
	logic       sixth_we;
	int         n_fail = 0; // Failed property checks.

	assign sixth_we = i_col_we && (n_we == 3'd5);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			n_we <= '0;
		end else if (i_col_we) begin
			n_we <= sixth_we ? 3'd0 : n_we + 3'd1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobe properties
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_load_after_sixth: assert property (@(posedge clk) disable iff (!i_arst_n)
		sixth_we |=> i_drain_load)
		else begin
			$error("drain load missing one cycle after the sixth column write");
			n_fail++;
		end

	a_load_only_after_sixth: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_drain_load |-> $past(sixth_we))
		else begin
			$error("drain load without a completed set of six columns");
			n_fail++;
		end

	a_four_rows: assert property (@(posedge clk) disable iff (!i_arst_n)
		$rose(i_row_valid) |-> i_row_valid [*4] ##1 !i_row_valid)
		else begin
			$error("row valid not high for exactly four cycles");
			n_fail++;
		end

	a_no_x: assert property (@(posedge clk) disable iff (!i_arst_n)
		!$isunknown({i_col_we, i_drain_load, i_row_shift, i_row_valid}))
		else begin
			$error("control strobe is unknown after reset");
			n_fail++;
		end

endmodule

`default_nettype wire

/* dv/tb_wino_inverse_xform.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_wino_inverse_xform
	import wino_num_pkg::*, wino_tile_pkg::*;
();

	logic        clk;
	logic        i_arst_n;
	logic        i_valid;
	acc_vec6_t   i_col;
	logic        o_valid;
	pix_row_t    o_row;

	int          tile [6][6]; // Row k of input column j.
	logic [31:0] rng_state;
	int          cyc;
	int          blocks_sent;
	int          out_count;
	int          checks;
	int          value_errors;
	int          other_errors;
	pix_row_t    exp_rows [$];
	int          exp_cycs [$];

	wino_inverse_xform dut0 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_valid  (i_valid),
		.i_col    (i_col),
		.o_valid  (o_valid),
		.o_row    (o_row)
	);

	bind wino_out_ctrl wino_assert assert0 (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_col_we     (o_col_we),
		.i_drain_load (o_drain_load),
		.i_row_shift  (o_row_shift),
		.i_row_valid  (o_row_valid)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int next_rand();
		rng_state = xorshift32(rng_state);
		return int'($signed(rng_state[19:0])); // About 20 bits so sums cannot overflow.
	endfunction

	function automatic int at_coef(input int r, input int k);
		int row [6];
		case (r)
			0: row = '{1, 1, 1, 1, 1, 0};
			1: row = '{0, 1, -1, 2, -2, 0};
			2: row = '{0, 1, 1, 4, 4, 0};
			default: row = '{0, 1, -1, 8, -8, 1};
		endcase
		return row[k];
	endfunction

	// Row r of A^T*M*A, rectified and sliced to bits 23..8.
	function automatic pix_row_t ref_tile(input int r);
		longint      y;
		logic [29:0] w;
		pix_t        px [4];
		for (int c = 0; c < 4; c++) begin
			y = 0;
			for (int k = 0; k < 6; k++) begin
				for (int j = 0; j < 6; j++) begin
					y += longint'(at_coef(r, k)) * tile[k][j] * at_coef(c, j);
				end
			end
			w     = y[29:0];
			px[c] = w[29] ? 16'd0 : w[23:8];
		end
		return '{px[0], px[1], px[2], px[3]};
	endfunction

	task automatic check_equal(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("FAIL @%0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mode 0 is constant, mode 1 scales v along the diagonal, others random.
	task automatic fill_tile(input int mode, input int v);
		for (int k = 0; k < 6; k++) begin
			for (int j = 0; j < 6; j++) begin
				case (mode)
					0: tile[k][j] = v;
					1: tile[k][j] = (k == j) ? v * (k + 1) : 0;
					default: tile[k][j] = next_rand();
				endcase
			end
		end
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#1;
		i_valid = 1'b0;
	endtask

	task automatic drive_beat(input int j);
		@(posedge clk);
		#1;
		i_valid = 1'b1;
		i_col   = '{acc_t'(tile[0][j]), acc_t'(tile[1][j]), acc_t'(tile[2][j]),
			acc_t'(tile[3][j]), acc_t'(tile[4][j]), acc_t'(tile[5][j])};
	endtask

	task automatic send_tile(input int gap_mask);
		int t;
		for (int j = 0; j < 6; j++) begin
			repeat (next_rand() & gap_mask) drive_idle();
			drive_beat(j);
		end
		t = cyc + 1; // Edge that samples the sixth beat.
		for (int r = 0; r < 4; r++) begin
			exp_rows.push_back(ref_tile(r));
			exp_cycs.push_back(t + 9 + r);
		end
		blocks_sent++;
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (exp_rows.size() != 0 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (exp_rows.size() != 0) begin
			$display("Timed out after %0d cycles with %0d output rows still missing",
				limit, exp_rows.size());
			other_errors++;
			exp_rows.delete();
			exp_cycs.delete();
		end
	endtask

	// Rows are stable at the falling edge.
	always @(negedge clk) begin
		if (i_arst_n && o_valid) begin
			out_count++;
			if (exp_rows.size() == 0) begin
				$display("Output beat at %0t ns arrived with no row expected", $time);
				other_errors++;
			end else begin
				check_equal("output row", o_row, exp_rows.pop_front());
				check_equal("output cycle", cyc + 1, exp_cycs.pop_front());
			end
		end
	end

	initial begin
		clk          = 1'b0;
		i_arst_n     = 1'b0;
		i_valid      = 1'b0;
		i_col        = '0;
		rng_state    = 32'd67;
		cyc          = 0;
		blocks_sent  = 0;
		out_count    = 0;
		checks       = 0;
		value_errors = 0;
		other_errors = 0;
		repeat (3) @(posedge clk);
		#1;
		i_arst_n = 1'b1;

		repeat (20) drive_idle();
		check_equal("beats while idle", out_count, 0);

		fill_tile(1, 256);       // Identity-like.
		send_tile(0);
		drive_idle();
		wait_drained(60);
		fill_tile(0, 256);       // All ones, scaled.
		send_tile(0);
		drive_idle();
		wait_drained(60);
		fill_tile(0, -1000);     // Negative sums.
		send_tile(0);
		drive_idle();
		wait_drained(60);
		fill_tile(0, 0);
		tile[0][0] = 'h0ABC_DE12; // Bits above the slice are dropped.
		tile[5][5] = 'h00F0_1234;
		send_tile(0);
		drive_idle();
		wait_drained(60);

		repeat (20) begin
			fill_tile(2, 0);
			send_tile(0);        // Back to back.
		end
		drive_idle();
		wait_drained(150);

		repeat (10) begin
			fill_tile(2, 0);
			send_tile(3);        // Up to three idle cycles before each beat.
		end
		drive_idle();
		wait_drained(150);
		repeat (20) drive_idle();
		check_equal("total output beats", out_count, 4 * blocks_sent);

		$display("Checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
			checks, value_errors, other_errors, dut0.ctrl0.assert0.n_fail);
		if (value_errors == 0 && other_errors == 0 && dut0.ctrl0.assert0.n_fail == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/wino_num_pkg.sv
src/wino_tile_pkg.sv
src/wino_adder6.sv
src/wino_at_stage.sv
src/wino_transpose_buf.sv
src/wino_out_ctrl.sv
src/wino_out_quant.sv
src/wino_inverse_xform.sv
dv/wino_assert.sv
dv/tb_wino_inverse_xform.sv
